//--- tests/bridge_input.txt
// kind addr wdata rdata: kind 0 read, 1 write, 2 bad opcode (wdata low byte), 3 short write
// rdata is the expected read word for kind 0 and unused otherwise
0 0000 00000000 00000000
0 0400 00000000 00000000
0 0600 00000000 00010000
1 0000 00000015 00000000
0 0000 00000000 00000015
1 0000 FFFFFFEA 00000000
0 0000 00000000 0000000A
0 0012 00000000 0000000A
1 0400 00000005 00000000
0 0400 00000000 00000005
1 04FF 000000FE 00000000
0 0401 00000000 00000006
1 0600 12345678 00000000
0 0600 00000000 00010000
0 0900 00000000 DEADBEEF
1 0900 00000003 00000000
0 0000 00000000 0000000A
2 0000 00000055 00000000
0 0400 00000000 00000006
3 0000 11000011 00000000
0 0000 00000000 0000000A
2 0600 000000A3 00000000
3 0400 07000007 00000000
0 0400 00000000 00000006
1 0000 0000001F 00000000
0 0000 00000000 0000001F
0 FF00 00000000 DEADBEEF
1 0400 00000001 00000000
0 0400 00000000 00000001
0 0700 00000000 DEADBEEF

//--- flist.f
rtl/bridge_pkg.sv
rtl/regmap_pkg.sv
rtl/cmd_decoder.sv
rtl/reg_bank.sv
rtl/resp_framer.sv
rtl/spi_reg_bridge.sv
tests/tb_spi_reg_bridge.sv

//--- tests/tb_spi_reg_bridge.sv
// Testbench that drives the byte-stream register bridge from a command and expectation file
`default_nettype none
`timescale 1ns/1ps

module tb_spi_reg_bridge;

    // Data-file lines and the cycle budget they allow
    localparam int N_LINES    = 30;
    localparam int MAX_CYCLES = 200 * N_LINES;

    logic                            i_sys_clk;
    logic                            rst_n_i;
    logic [bridge_pkg::BYTE_W-1:0]   s_tdata_i;
    logic                            s_tvalid_i;
    logic                            s_tlast_i;
    logic                            s_tready_o;
    logic [bridge_pkg::BYTE_W-1:0]   m_tdata_o;
    logic                            m_tvalid_o;
    logic                            m_tlast_o;
    logic                            m_tready_i;
    logic [regmap_pkg::LED_W-1:0]    led_n_o;
    logic                            mux_sel_o;
    logic [regmap_pkg::MUX_CH_W-1:0] mux_ch_o;

    // Four words per line holding kind, address, write data and expected read data
    logic [31:0] vectors [0:4*N_LINES-1];
    // Expected answer bytes as {tlast, data} with the oldest first
    logic [8:0]  exp_q [$];
    // Expected pin state
    logic [regmap_pkg::LED_W-1:0]  led_n_exp;
    logic [regmap_pkg::MUX_CH_W:0] mux_exp;
    logic [31:0] rng;
    logic        bp_on;
    int          cycles;

    spi_reg_bridge spi_reg_bridge_i (
        .i_sys_clk  (i_sys_clk),
        .rst_n_i    (rst_n_i),
        .s_tdata_i  (s_tdata_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tlast_i  (s_tlast_i),
        .s_tready_o (s_tready_o),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tlast_o  (m_tlast_o),
        .m_tready_i (m_tready_i),
        .led_n_o    (led_n_o),
        .mux_sel_o  (mux_sel_o),
        .mux_ch_o   (mux_ch_o)
    );

    // 8 ns clock
    always #4 i_sys_clk = ~i_sys_clk;

    // ========================================================================
    // Helpers
    // ========================================================================

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge i_sys_clk);
        #1;
    endtask

    // Reset for 2 cycles and return the pin model to reset values
    task automatic apply_reset();
        rst_n_i = 1'b0;
        repeat (2) @(posedge i_sys_clk);
        #1;
        rst_n_i   = 1'b1;
        led_n_exp = ~regmap_pkg::LED_RESET;
        mux_exp   = regmap_pkg::MUX_RESET;
    endtask

    // Called 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_byte(input logic [7:0] data, input logic last);
        logic done;
        s_tdata_i  = data;
        s_tvalid_i = 1'b1;
        s_tlast_i  = last;
        done       = 1'b0;
        while (!done) begin
            // Ready only changes on an edge so mid-cycle tells the outcome
            @(negedge i_sys_clk);
            done = s_tready_o;
            @(posedge i_sys_clk);
            #1;
        end
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
    endtask

    task automatic send_frame(input int line);
        logic [1:0]  kind;
        logic [15:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        kind  = vectors[4*line][1:0];
        addr  = vectors[4*line+1][15:0];
        wdata = vectors[4*line+2];
        rdata = vectors[4*line+3];
        case (kind)
            2'd0: begin
                // Read answer is opcode then data MSB first
                exp_q.push_back({1'b0, bridge_pkg::OP_READ_RESP});
                for (int b = 3; b >= 0; b--) begin
                    exp_q.push_back({b == 0, rdata[8*b +: 8]});
                end
                send_byte(bridge_pkg::OP_READ_REQ, 1'b0);
                send_byte(addr[15:8], 1'b0);
                send_byte(addr[7:0], 1'b1);
            end
            2'd1: begin
                exp_q.push_back({1'b1, bridge_pkg::OP_WRITE_RESP});
                // Only LED and mux windows hold writable state
                if (addr[15:8] == regmap_pkg::ADDR_LED[15:8]) begin
                    led_n_exp = ~wdata[regmap_pkg::LED_W-1:0];
                end
                if (addr[15:8] == regmap_pkg::ADDR_MUX[15:8]) begin
                    mux_exp = wdata[regmap_pkg::MUX_CH_W:0];
                end
                send_byte(bridge_pkg::OP_WRITE_REQ, 1'b0);
                send_byte(addr[15:8], 1'b0);
                send_byte(addr[7:0], 1'b0);
                for (int b = 3; b >= 0; b--) begin
                    send_byte(wdata[8*b +: 8], b == 0);
                end
            end
            2'd2: begin
                // Unknown opcode from the data column is skipped with no answer
                send_byte(wdata[7:0], 1'b0);
                send_byte(addr[15:8], 1'b0);
                send_byte(addr[7:0], 1'b1);
            end
            default: begin
                // Write frame cut off after its first data byte
                send_byte(bridge_pkg::OP_WRITE_REQ, 1'b0);
                send_byte(addr[15:8], 1'b0);
                send_byte(addr[7:0], 1'b0);
                send_byte(wdata[31:24], 1'b1);
            end
        endcase
    endtask

    task automatic wait_for_answers();
        while (exp_q.size() != 0) begin
            @(posedge i_sys_clk);
            #1;
        end
    endtask

    task automatic check_pins();
        compare_value("led_n_o", led_n_o, led_n_exp);
        compare_value("mux_sel_o", mux_sel_o, mux_exp[0]);
        compare_value("mux_ch_o", mux_ch_o, mux_exp[regmap_pkg::MUX_CH_W:1]);
    endtask

    // ========================================================================
    // Monitor, back-pressure and timeout
    // ========================================================================

    // Sampled mid-cycle so a byte seen here moves on the next rising edge
    always @(negedge i_sys_clk) begin : watch_answers
        logic [8:0] item;
        if (rst_n_i && m_tvalid_o && m_tready_i) begin
            if (exp_q.size() == 0) begin
                stop_on_error("A response byte arrived with no answer pending");
            end else begin
                item = exp_q.pop_front();
                compare_value("m_tdata_o", m_tdata_o, item[7:0]);
                compare_value("m_tlast_o", m_tlast_o, item[8]);
            end
        end
    end

    // Ready low about a third of the time while back-pressure is on
    always @(posedge i_sys_clk) begin
        #1;
        if (bp_on) begin
            rng        = next_random(rng);
            m_tready_i = (rng % 3) != 0;
        end else begin
            m_tready_i = 1'b1;
        end
    end

    always @(posedge i_sys_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error($sformatf("Timeout: responses never arrived within %0d cycles",
                                    MAX_CYCLES));
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        i_sys_clk  = 1'b0;
        rst_n_i    = 1'b0;
        s_tdata_i  = '0;
        s_tvalid_i = 1'b0;
        s_tlast_i  = 1'b0;
        m_tready_i = 1'b1;
        bp_on      = 1'b0;
        rng        = 32'hb85f;
        cycles     = 0;
        $readmemh("tests/bridge_input.txt", vectors);

        // One frame at a time with pins checked after each write answer
        apply_reset();
        compare_value("led_n_o", led_n_o, {regmap_pkg::LED_W{1'b1}});
        for (int i = 0; i < N_LINES; i++) begin
            send_frame(i);
            if (vectors[4*i] < 2) begin
                wait_for_answers();
            end else begin
                idle_cycles(4);
            end
            if (vectors[4*i] == 1) begin
                check_pins();
            end
        end

        // Same file again from reset with frames back to back under back-pressure
        apply_reset();
        bp_on = 1'b1;
        for (int i = 0; i < N_LINES; i++) begin
            send_frame(i);
        end
        wait_for_answers();
        idle_cycles(8);
        bp_on = 1'b0;

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/spi_reg_bridge.sv
// Byte-stream register bridge top: decoder, register bank and response framer in a chain
`default_nettype none
`timescale 1ns/1ps

module spi_reg_bridge (
    input  wire logic                          i_sys_clk,
    input  wire logic                          rst_n_i,
    // Command stream in
    input  wire logic [bridge_pkg::BYTE_W-1:0] s_tdata_i,
    input  wire logic                          s_tvalid_i,
    input  wire logic                          s_tlast_i,
    output logic                               s_tready_o,
    // Response stream out
    output logic [bridge_pkg::BYTE_W-1:0]      m_tdata_o,
    output logic                               m_tvalid_o,
    output logic                               m_tlast_o,
    input  wire logic                          m_tready_i,
    // Peripheral pins
    output logic [regmap_pkg::LED_W-1:0]       led_n_o,
    output logic                               mux_sel_o,
    output logic [regmap_pkg::MUX_CH_W-1:0]    mux_ch_o
);

    // ========================================================================
    // Internal handshakes
    // ========================================================================

    // Decoder to bank
    logic                          req_valid;
    logic                          req_write;
    logic [bridge_pkg::ADDR_W-1:0] req_addr;
    logic [bridge_pkg::WORD_W-1:0] req_wdata;
    logic                          req_ready;

    // Bank to framer
    logic                          res_valid;
    logic                          res_write;
    logic [bridge_pkg::WORD_W-1:0] res_rdata;
    logic                          res_ready;

    cmd_decoder cmd_decoder_i (
        .i_sys_clk   (i_sys_clk),
        .rst_n_i     (rst_n_i),
        .s_tdata_i   (s_tdata_i),
        .s_tvalid_i  (s_tvalid_i),
        .s_tlast_i   (s_tlast_i),
        .s_tready_o  (s_tready_o),
        .req_valid_o (req_valid),
        .req_write_o (req_write),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .req_ready_i (req_ready)
    );

    reg_bank reg_bank_i (
        .i_sys_clk   (i_sys_clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid),
        .req_write_i (req_write),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .req_ready_o (req_ready),
        .res_valid_o (res_valid),
        .res_write_o (res_write),
        .res_rdata_o (res_rdata),
        .res_ready_i (res_ready),
        .led_n_o     (led_n_o),
        .mux_sel_o   (mux_sel_o),
        .mux_ch_o    (mux_ch_o)
    );

    resp_framer resp_framer_i (
        .i_sys_clk   (i_sys_clk),
        .rst_n_i     (rst_n_i),
        .res_valid_i (res_valid),
        .res_write_i (res_write),
        .res_rdata_i (res_rdata),
        .res_ready_o (res_ready),
        .m_tdata_o   (m_tdata_o),
        .m_tvalid_o  (m_tvalid_o),
        .m_tlast_o   (m_tlast_o),
        .m_tready_i  (m_tready_i)
    );

endmodule

`default_nettype wire

//--- rtl/resp_framer.sv
// Response framer: turns register results into answer frames on the output byte stream
`default_nettype none
`timescale 1ns/1ps

module resp_framer (
    input  wire logic                          i_sys_clk,
    input  wire logic                          rst_n_i,
    // Result from the bank
    input  wire logic                          res_valid_i,
    input  wire logic                          res_write_i,
    input  wire logic [bridge_pkg::WORD_W-1:0] res_rdata_i,
    output logic                               res_ready_o,
    // Outgoing byte stream
    output logic [bridge_pkg::BYTE_W-1:0]      m_tdata_o,
    output logic                               m_tvalid_o,
    output logic                               m_tlast_o,
    input  wire logic                          m_tready_i
);

    // ========================================================================
    // Byte shifter
    // ========================================================================

    // Whole answer, current byte at the top
    logic [bridge_pkg::READ_RESP_LEN*bridge_pkg::BYTE_W-1:0] sr_q;
    // Bytes left after the current one
    logic [2:0] left_q;
    logic       take;
    logic       beat;

    // One answer at a time
    assign res_ready_o = !m_tvalid_o;
    assign take        = res_valid_i && res_ready_o;
    assign beat        = m_tvalid_o && m_tready_i;

    assign m_tdata_o = sr_q[bridge_pkg::READ_RESP_LEN*bridge_pkg::BYTE_W-1 -: bridge_pkg::BYTE_W];
    assign m_tlast_o = (left_q == '0);

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            m_tvalid_o <= 1'b0;
            left_q     <= '0;
        end else if (take) begin
            m_tvalid_o <= 1'b1;
            // Write answer is the opcode only
            left_q     <= res_write_i ? 3'd0 : 3'(bridge_pkg::READ_RESP_LEN - 1);
        end else if (beat) begin
            if (left_q == '0) begin
                m_tvalid_o <= 1'b0;
            end else begin
                left_q <= left_q - 3'd1;
            end
        end
    end

    // Payload, loaded opcode first
    always_ff @(posedge i_sys_clk) begin
        if (take) begin
            if (res_write_i) begin
                sr_q <= {bridge_pkg::OP_WRITE_RESP, {bridge_pkg::WORD_W{1'b0}}};
            end else begin
                sr_q <= {bridge_pkg::OP_READ_RESP, res_rdata_i};
            end
        end else if (beat) begin
            sr_q <= {sr_q[(bridge_pkg::READ_RESP_LEN-1)*bridge_pkg::BYTE_W-1:0],
                     {bridge_pkg::BYTE_W{1'b0}}};
        end
    end

    // Stream rule, byte and last frozen under back-pressure
    a_stream_hold : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) &&
                                      $stable(m_tlast_o));

endmodule

`default_nettype wire

//--- rtl/reg_bank.sv
// Register bank: decodes request windows and runs reads and writes on LED, mux and version
`default_nettype none
`timescale 1ns/1ps

module reg_bank (
    input  wire logic                                i_sys_clk,
    input  wire logic                                rst_n_i,
    // Request from the decoder
    input  wire logic                                req_valid_i,
    input  wire logic                                req_write_i,
    input  wire logic [bridge_pkg::ADDR_W-1:0]       req_addr_i,
    input  wire logic [bridge_pkg::WORD_W-1:0]       req_wdata_i,
    output logic                                     req_ready_o,
    // Result to the framer
    output logic                                     res_valid_o,
    output logic                                     res_write_o,
    output logic [bridge_pkg::WORD_W-1:0]            res_rdata_o,
    input  wire logic                                res_ready_i,
    // Peripheral pins
    output logic [regmap_pkg::LED_W-1:0]             led_n_o,
    output logic                                     mux_sel_o,
    output logic [regmap_pkg::MUX_CH_W-1:0]          mux_ch_o
);

    // ========================================================================
    // Address decode
    // ========================================================================

    logic [regmap_pkg::PAGE_MSB-regmap_pkg::PAGE_LSB:0] page;
    logic take;
    logic sel_led;
    logic sel_mux;
    logic sel_ver;
    logic [bridge_pkg::WORD_W-1:0] rdata_d;

    // Registers
    logic [regmap_pkg::LED_W-1:0]  led_q;
    // Mode in bit 0, channel above it
    logic [regmap_pkg::MUX_CH_W:0] mux_q;

    // New request fits when the result slot is free or draining
    assign req_ready_o = !res_valid_o || res_ready_i;
    assign take        = req_valid_i && req_ready_o;

    assign page    = req_addr_i[regmap_pkg::PAGE_MSB:regmap_pkg::PAGE_LSB];
    assign sel_led = page == regmap_pkg::ADDR_LED[regmap_pkg::PAGE_MSB:regmap_pkg::PAGE_LSB];
    assign sel_mux = page == regmap_pkg::ADDR_MUX[regmap_pkg::PAGE_MSB:regmap_pkg::PAGE_LSB];
    assign sel_ver = page == regmap_pkg::ADDR_VERSION[regmap_pkg::PAGE_MSB:regmap_pkg::PAGE_LSB];

    // Read mux, anything outside the three windows reads a marker word
    always_comb begin
        rdata_d = regmap_pkg::UNMAPPED_WORD;
        if (sel_led) begin
            rdata_d = bridge_pkg::WORD_W'(led_q);
        end else if (sel_mux) begin
            rdata_d = bridge_pkg::WORD_W'(mux_q);
        end else if (sel_ver) begin
            rdata_d = regmap_pkg::VERSION_WORD;
        end
    end

    // ========================================================================
    // Registers and result handshake
    // ========================================================================

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            led_q       <= regmap_pkg::LED_RESET;
            mux_q       <= regmap_pkg::MUX_RESET;
            res_valid_o <= 1'b0;
        end else begin
            if (take) begin
                res_valid_o <= 1'b1;
            end else if (res_ready_i) begin
                res_valid_o <= 1'b0;
            end
            // Version and unmapped windows ignore writes
            if (take && req_write_i && sel_led) begin
                led_q <= req_wdata_i[regmap_pkg::LED_W-1:0];
            end
            if (take && req_write_i && sel_mux) begin
                mux_q <= req_wdata_i[regmap_pkg::MUX_CH_W:0];
            end
        end
    end

    // Result payload
    always_ff @(posedge i_sys_clk) begin
        if (take) begin
            res_write_o <= req_write_i;
            res_rdata_o <= rdata_d;
        end
    end

    // Active-low LED pads
    assign led_n_o   = ~led_q;
    assign mux_sel_o = mux_q[0];
    assign mux_ch_o  = mux_q[regmap_pkg::MUX_CH_W:1];

    // A held result is never overwritten by the next request
    a_res_hold : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_write_o) &&
                                        $stable(res_rdata_o));

endmodule

`default_nettype wire

//--- rtl/cmd_decoder.sv
// Command decoder: parses read and write frames from the byte stream into requests
`default_nettype none
`timescale 1ns/1ps

module cmd_decoder (
    input  wire logic                          i_sys_clk,
    input  wire logic                          rst_n_i,
    // Incoming byte stream
    input  wire logic [bridge_pkg::BYTE_W-1:0] s_tdata_i,
    input  wire logic                          s_tvalid_i,
    input  wire logic                          s_tlast_i,
    output logic                               s_tready_o,
    // Register request
    output logic                               req_valid_o,
    output logic                               req_write_o,
    output logic [bridge_pkg::ADDR_W-1:0]      req_addr_o,
    output logic [bridge_pkg::WORD_W-1:0]      req_wdata_o,
    input  wire logic                          req_ready_i
);

    // ========================================================================
    // Frame parser state
    // ========================================================================

    // Index of the next byte within the frame, 0 means opcode expected
    logic [2:0] cnt_q;
    // Dropping bytes until tlast
    logic       skip_q;
    // Frame in progress is a write
    logic       wr_q;
    // Address and data bytes, newest byte at the bottom
    logic [bridge_pkg::ADDR_W+bridge_pkg::WORD_W-1:0] sr_q;
    logic [bridge_pkg::ADDR_W+bridge_pkg::WORD_W-1:0] sr_next;

    logic       accept;
    logic       known_op;
    logic [2:0] last_idx;

    // Stall input only while a request waits for the bank
    assign s_tready_o = !req_valid_o || req_ready_i;
    assign accept     = s_tvalid_i && s_tready_o;

    assign known_op = (s_tdata_i == bridge_pkg::OP_READ_REQ) ||
                      (s_tdata_i == bridge_pkg::OP_WRITE_REQ);

    // Position of the final byte for the current frame kind
    assign last_idx = wr_q ? 3'(bridge_pkg::WRITE_FRAME_LEN - 1)
                           : 3'(bridge_pkg::READ_FRAME_LEN - 1);

    assign sr_next = {sr_q[bridge_pkg::ADDR_W+bridge_pkg::WORD_W-bridge_pkg::BYTE_W-1:0],
                      s_tdata_i};

    // ========================================================================
    // Control
    // ========================================================================

    always_ff @(posedge i_sys_clk) begin
        if (!rst_n_i) begin
            cnt_q       <= '0;
            skip_q      <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            // Bank took the held request
            if (req_ready_i) begin
                req_valid_o <= 1'b0;
            end
            if (accept) begin
                if (skip_q) begin
                    skip_q <= !s_tlast_i;
                end else if (cnt_q == '0) begin
                    // Unknown opcode drops the rest of its frame
                    // a lone opcode with tlast is a short frame
                    if (!s_tlast_i) begin
                        cnt_q  <= known_op ? 3'd1 : 3'd0;
                        skip_q <= !known_op;
                    end
                end else if (cnt_q == last_idx) begin
                    req_valid_o <= 1'b1;
                    cnt_q       <= '0;
                    // Trailing bytes are ignored up to tlast
                    skip_q      <= !s_tlast_i;
                end else if (s_tlast_i) begin
                    // Short frame, no request and no answer
                    cnt_q <= '0;
                end else begin
                    cnt_q <= cnt_q + 3'd1;
                end
            end
        end
    end

    // ========================================================================
    // Payload
    // ========================================================================

    always_ff @(posedge i_sys_clk) begin
        if (accept && !skip_q) begin
            if (cnt_q == '0) begin
                wr_q <= (s_tdata_i == bridge_pkg::OP_WRITE_REQ);
            end else begin
                sr_q <= sr_next;
            end
            // Request fields load together with req_valid_o
            if (cnt_q != '0 && cnt_q == last_idx) begin
                req_write_o <= wr_q;
                req_wdata_o <= sr_next[bridge_pkg::WORD_W-1:0];
                // Read frames end right after the address
                req_addr_o  <= wr_q ? sr_next[bridge_pkg::ADDR_W+bridge_pkg::WORD_W-1:
                                              bridge_pkg::WORD_W]
                                    : sr_next[bridge_pkg::ADDR_W-1:0];
            end
        end
    end

    // Held request must not change under the bank
    a_req_hold : assert property (@(posedge i_sys_clk) disable iff (!rst_n_i)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_write_o) &&
                                        $stable(req_addr_o) && $stable(req_wdata_o));

endmodule

`default_nettype wire

//--- rtl/regmap_pkg.sv
// Register map of the bridge: slave addresses, field widths and reset values
`default_nettype none

package regmap_pkg;

    // ========================================================================
    // Address decode
    // ========================================================================

    // Base of each slave window
    localparam logic [15:0] ADDR_LED     = 16'h0000;
    localparam logic [15:0] ADDR_MUX     = 16'h0400;
    localparam logic [15:0] ADDR_VERSION = 16'h0600;

    // Only these address bits pick a slave, giving 256-byte windows
    localparam int PAGE_MSB = 15;
    localparam int PAGE_LSB = 8;

    // ========================================================================
    // Fields and reset values
    // ========================================================================

    // Five LEDs, pins are active low
    localparam int LED_W = 5;

    // Motor channel select in the mux register
    localparam int MUX_CH_W = 2;

    // All LEDs off after reset
    localparam logic [LED_W-1:0] LED_RESET = '0;

    // Passthrough mode on channel 0, laid out as {channel, mode}
    localparam logic [MUX_CH_W:0] MUX_RESET = '0;

    // Fixed read-only words
    localparam logic [31:0] VERSION_WORD  = 32'h0001_0000;
    localparam logic [31:0] UNMAPPED_WORD = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

//--- rtl/bridge_pkg.sv
// Command-frame protocol constants for the byte-stream register bridge
`default_nettype none

package bridge_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    // One stream beat carries one byte
    localparam int BYTE_W = 8;

    // Register data, sent most significant byte first
    localparam int WORD_W = 32;

    // Register address, big endian on the wire
    localparam int ADDR_W = 16;

    // ========================================================================
    // Opcodes
    // ========================================================================

    // Requests from the host
    localparam logic [BYTE_W-1:0] OP_READ_REQ  = 8'hA1;
    localparam logic [BYTE_W-1:0] OP_WRITE_REQ = 8'hA2;

    // Answers back to the host
    localparam logic [BYTE_W-1:0] OP_READ_RESP  = 8'hA3;
    localparam logic [BYTE_W-1:0] OP_WRITE_RESP = 8'hA4;

    // ========================================================================
    // Frame lengths in bytes
    // ========================================================================

    // Opcode plus two address bytes
    localparam int READ_FRAME_LEN = 3;

    // Opcode, two address bytes, four data bytes
    localparam int WRITE_FRAME_LEN = 7;

    // Opcode plus four data bytes; a write answer is the opcode alone
    localparam int READ_RESP_LEN = 5;

endpackage

`default_nettype wire
